// File: tests/fir_trace.txt
# test <name> <gaps 0|1> <length, decimal> <status hex: idle started done cleared>
# then 11 taps, the samples and the expected results, all hex
test impulse 0 12 2 1 6 2
1 2 3 4 5 6 7 8 9 a b
1 0 0 0 0 0 0 0 0 0 0 0
1 2 3 4 5 6 7 8 9 a b 0
test ramp 1 14 2 1 6 2
1 1 1 1 1 1 1 1 1 1 1
1 2 3 4 5 6 7 8 9 a b c d e
1 3 6 a f 15 1c 24 2d 37 42 4d 58 63
test wrap 1 5 2 1 6 2
ffffffff 2 10000 0 0 0 0 0 0 0 0
3 80000001 10001 ffffffff 10
fffffffd 80000005 20001 30003 ffee

// File: filelist.f
logic/fir_pkg.sv
logic/fir_cfg_regs.sv
logic/fir_seq_fsm.sv
logic/fir_tap_counter.sv
logic/fir_sample_ring.sv
logic/fir_mac.sv
logic/fir_out_fifo.sv
logic/fir_top.sv
tests/fir_tb.sv

// File: Makefile
SIM_BIN = fir_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the FIR testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build output"

test:
	verilator --binary --timing -Wno-fatal --top-module fir_tb -f filelist.f -o $(SIM_BIN)
	./obj_dir/$(SIM_BIN)

clean:
	rm -rf obj_dir

// File: tests/fir_tb.sv
`timescale 1ns/1ps

module fir_tb
    import fir_pkg::*;
();

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    logic  awready;
    logic  wready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  ss_tready;
    logic  sm_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;

    // trace contents, flat queues indexed by running offsets
    string      name_q[$];
    int         gaps_q[$];
    int         len_q[$];
    ap_status_t st_q[$];
    data_t      tap_q[$];
    data_t      smp_q[$];
    data_t      res_q[$];
    int         cycles;
    int         limit;

    fir_top dut_i (.*);

    // 8 ns period
    always #4 axis_clk = ~axis_clk;

    // ******************************
    // run limit
    // ******************************
    always @(posedge axis_clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
            fail_stop($sformatf("timeout, the run hung for %0d cycles", cycles));
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            fail_stop($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input ap_status_t exp, input ap_status_t act);
        if (act !== exp)
            fail_stop($sformatf("Fail %s: expected status %b, actual %b", name, exp, act));
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_stop($sformatf("Fail %s: expected tlast %b, actual %b", name, exp, act));
    endtask

    // ******************************
    // trace loading
    // ******************************
    task automatic load_trace();
        int    fd;
        int    total;
        int    gaps;
        int    len;
        string tok;
        string name;
        string rest;
        data_t v;
        fd = $fopen("tests/fir_trace.txt", "r");
        if (fd == 0)
            fail_stop("cannot open tests/fir_trace.txt");
        total = 0;
        while ($fscanf(fd, "%s", tok) == 1)
        begin
            if (tok.substr(0, 0) == "#")
            begin
                // skip the rest of a comment line
                void'($fgets(rest, fd));
            end
            else if (tok != "test")
                fail_stop($sformatf("unexpected word %s in the trace file", tok));
            else
            begin
                if ($fscanf(fd, "%s %d %d", name, gaps, len) != 3)
                    fail_stop("broken test header in the trace file");
                name_q.push_back(name);
                gaps_q.push_back(gaps);
                len_q.push_back(len);
                // idle, started, done, cleared
                repeat (4)
                begin
                    void'($fscanf(fd, "%h", v));
                    st_q.push_back(ap_status_t'(v[2:0]));
                end
                repeat (NUM_TAPS)
                begin
                    void'($fscanf(fd, "%h", v));
                    tap_q.push_back(v);
                end
                repeat (len)
                begin
                    void'($fscanf(fd, "%h", v));
                    smp_q.push_back(v);
                end
                repeat (len)
                begin
                    void'($fscanf(fd, "%h", v));
                    res_q.push_back(v);
                end
                total += len;
            end
        end
        $fclose(fd);
        limit = total * (NUM_TAPS + 8) + 200;
    endtask

    // ******************************
    // axi-lite drivers
    // ******************************
    task automatic write_reg(input addr_t a, input data_t d);
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = a;
        wvalid  = 1'b1;
        wdata   = d;
        // settle before the rising edge
        #1;
        while (!(awready && wready))
        begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input addr_t a, output data_t d);
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = a;
        rready  = 1'b1;
        #1;
        // previous response still pending
        while (!arready)
        begin
            @(negedge axis_clk);
            #1;
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        #1;
        while (!rvalid)
        begin
            @(negedge axis_clk);
            #1;
        end
        d = rdata;
    endtask

    // ******************************
    // stream drivers
    // ******************************
    task automatic feed_samples(input int base, input int len, input int gaps);
        int   k;
        logic taken;
        k     = 0;
        taken = 1'b0;
        while (k < len)
        begin
            @(negedge axis_clk);
            // new beat only once the previous one is taken
            if (taken || !ss_tvalid)
            begin
                ss_tvalid = (gaps == 0) || (($urandom % 4) != 0);
                ss_tdata  = smp_q[base + k];
                ss_tlast  = (k == len - 1);
            end
            taken = 1'b0;
            #1;
            if (ss_tvalid && ss_tready)
            begin
                k++;
                taken = 1'b1;
            end
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_results(input string name, input int base, input int len,
                                   input int gaps);
        int k;
        k = 0;
        if (gaps != 0)
        begin
            // output held off until the fifo is full
            sm_tready = 1'b0;
            repeat (OUT_FIFO_DEPTH * (NUM_TAPS + 2) + 8)
                @(negedge axis_clk);
            #1;
            // full fifo blocks the input stream
            if (len > OUT_FIFO_DEPTH)
                check_last({name, " ss_tready while full"}, 1'b0, ss_tready);
        end
        while (k < len)
        begin
            @(negedge axis_clk);
            sm_tready = (gaps == 0) || (($urandom % 2) != 0);
            #1;
            if (sm_tvalid && sm_tready)
            begin
                check_data($sformatf("%s beat %0d", name, k), res_q[base + k], sm_tdata);
                check_last($sformatf("%s beat %0d", name, k), (k == len - 1), sm_tlast);
                k++;
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    // ******************************
    // one run
    // ******************************
    task automatic run_test(input int t, input int tap_base, input int smp_base);
        string name;
        int    len;
        data_t rd;
        name = name_q[t];
        len  = len_q[t];

        // idle before configuration
        read_reg(ADDR_CTRL, rd);
        check_status(name, st_q[4 * t], ap_status_t'(rd[2:0]));

        for (int i = 0; i < NUM_TAPS; i++)
            write_reg(ADDR_TAP_BASE + addr_t'(4 * i), tap_q[tap_base + i]);
        write_reg(ADDR_LENGTH, data_t'(len));
        write_reg(ADDR_CTRL, 32'h1);

        // started, waiting for the first sample
        read_reg(ADDR_CTRL, rd);
        check_status(name, st_q[4 * t + 1], ap_status_t'(rd[2:0]));
        read_reg(ADDR_LENGTH, rd);
        check_data({name, " length"}, data_t'(len), rd);
        // busy, so this tap write is dropped
        write_reg(ADDR_TAP_BASE, ~tap_q[tap_base]);

        fork
            feed_samples(smp_base, len, gaps_q[t]);
            collect_results(name, smp_base, len, gaps_q[t]);
        join

        // done once the fifo drains
        rd = '0;
        while (!rd[2])
            read_reg(ADDR_CTRL, rd);
        check_status(name, st_q[4 * t + 2], ap_status_t'(rd[2:0]));
        read_reg(ADDR_CTRL, rd);
        check_status(name, st_q[4 * t + 3], ap_status_t'(rd[2:0]));

        for (int i = 0; i < NUM_TAPS; i++)
        begin
            read_reg(ADDR_TAP_BASE + addr_t'(4 * i), rd);
            check_data($sformatf("%s tap %0d", name, i), tap_q[tap_base + i], rd);
        end
    endtask

    initial
    begin
        data_t rd;
        int    tap_base;
        int    smp_base;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        cycles     = 0;
        limit      = 0;
        void'($urandom(61));
        load_trace();

        // two cycles of reset
        repeat (2)
            @(negedge axis_clk);
        axis_rst_n = 1'b1;

        // hole in the register map
        read_reg(12'h004, rd);
        check_data("unmapped_read", data_t'('1), rd);

        tap_base = 0;
        smp_base = 0;
        for (int t = 0; t < name_q.size(); t++)
        begin
            run_test(t, tap_base, smp_base);
            tap_base += NUM_TAPS;
            smp_base += len_q[t];
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: logic/fir_top.sv
`timescale 1ns/1ps

module fir_top
    import fir_pkg::*;
(
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    // axi-lite write
    input  logic  awvalid,
    input  addr_t awaddr,
    input  logic  wvalid,
    input  data_t wdata,
    output logic  awready,
    output logic  wready,
    // axi-lite read
    input  logic  arvalid,
    input  addr_t araddr,
    input  logic  rready,
    output logic  arready,
    output logic  rvalid,
    output data_t rdata,
    // stream in, run end comes from the length register
    input  logic  ss_tvalid,
    input  data_t ss_tdata,
    input  logic  ss_tlast,
    output logic  ss_tready,
    // stream out
    input  logic  sm_tready,
    output logic  sm_tvalid,
    output data_t sm_tdata,
    output logic  sm_tlast
);

    ap_status_t   status;
    logic         start_req;
    logic         done_clear;
    length_t      run_length;
    length_t      remaining;
    data_t        tap_coef;
    tap_idx_t     tap_idx;
    logic         first_tap;
    logic         last_tap;
    logic         last_sample;
    logic         sample_accept;
    logic         mac_en;
    logic         result_push;
    data_t        sample_out;
    data_t        mac_result;
    logic         has_free_slot;
    logic         fifo_empty;
    stream_beat_t push_beat;
    stream_beat_t pop_beat;

    // ******************************
    // beat packing
    // ******************************
    assign push_beat = '{data: mac_result, last: last_sample};
    assign sm_tdata  = pop_beat.data;
    assign sm_tlast  = pop_beat.last;

    fir_cfg_regs cfg_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .awready(awready), .wready(wready),
        .arvalid(arvalid), .araddr(araddr), .rready(rready),
        .arready(arready), .rvalid(rvalid), .rdata(rdata),
        .status(status), .tap_idx(tap_idx), .remaining(remaining),
        .start_req(start_req), .done_clear(done_clear),
        .run_length(run_length), .tap_coef(tap_coef)
    );

    fir_seq_fsm seq_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .start_req(start_req), .done_clear(done_clear), .ss_tvalid(ss_tvalid),
        .has_free_slot(has_free_slot), .last_tap(last_tap),
        .last_sample(last_sample), .fifo_empty(fifo_empty),
        .ss_tready(ss_tready), .sample_accept(sample_accept),
        .mac_en(mac_en), .result_push(result_push), .status(status)
    );

    fir_tap_counter cnt_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .start_req(start_req), .run_length(run_length),
        .sample_accept(sample_accept), .mac_en(mac_en),
        .tap_idx(tap_idx), .first_tap(first_tap), .last_tap(last_tap),
        .remaining(remaining), .last_sample(last_sample)
    );

    fir_sample_ring ring_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .start_req(start_req), .sample_accept(sample_accept),
        .ss_tdata(ss_tdata), .tap_idx(tap_idx), .sample_out(sample_out)
    );

    fir_mac mac_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .mac_en(mac_en), .first_tap(first_tap),
        .sample_out(sample_out), .tap_coef(tap_coef), .result(mac_result)
    );

    fir_out_fifo fifo_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .result_push(result_push), .push_beat(push_beat), .sm_tready(sm_tready),
        .sm_tvalid(sm_tvalid), .pop_beat(pop_beat),
        .has_free_slot(has_free_slot), .fifo_empty(fifo_empty)
    );

endmodule

// File: logic/fir_out_fifo.sv
`timescale 1ns/1ps

module fir_out_fifo
    import fir_pkg::*;
(
    input  logic         axis_clk,
    input  logic         axis_rst_n,
    input  logic         result_push,
    input  stream_beat_t push_beat,
    input  logic         sm_tready,
    output logic         sm_tvalid,
    output stream_beat_t pop_beat,
    output logic         has_free_slot,
    output logic         fifo_empty
);

    stream_beat_t          mem [OUT_FIFO_DEPTH];
    stream_beat_t          head;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  pop;

    // pointer step with wrap at depth
    function automatic logic [FIFO_PTR_W-1:0] step(input logic [FIFO_PTR_W-1:0] ptr);
        return (ptr == FIFO_PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo_empty    = (count == '0);
    assign has_free_slot = (count < FIFO_CNT_W'(OUT_FIFO_DEPTH));
    assign sm_tvalid     = !fifo_empty;
    assign pop           = sm_tvalid & sm_tready;

    // last only meaningful on a valid beat
    assign head = mem[rd_ptr];
    always_comb
    begin
        pop_beat      = head;
        pop_beat.last = head.last & sm_tvalid;
    end

    // pointers and occupancy
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (result_push)
                wr_ptr <= step(wr_ptr);
            if (pop)
                rd_ptr <= step(rd_ptr);
            // push and pop together leave the count alone
            case ({result_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge axis_clk)
    begin
        if (result_push)
            mem[wr_ptr] <= push_beat;
    end

endmodule

// File: logic/fir_mac.sv
`timescale 1ns/1ps

module fir_mac
    import fir_pkg::*;
(
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    input  logic  mac_en,
    input  logic  first_tap,
    input  data_t sample_out,
    input  data_t tap_coef,
    output data_t result
);

    data_t product;
    data_t acc;

    // low word of the product, wraps mod 2^32
    assign product = sample_out * tap_coef;
    assign result  = acc;

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            acc <= '0;
        else if (mac_en)
        begin
            // tap 0 starts a fresh sum
            if (first_tap)
                acc <= product;
            else
                acc <= acc + product;
        end
    end

endmodule

// File: logic/fir_sample_ring.sv
`timescale 1ns/1ps

module fir_sample_ring
    import fir_pkg::*;
(
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     start_req,
    input  logic     sample_accept,
    input  data_t    ss_tdata,
    input  tap_idx_t tap_idx,
    output data_t    sample_out
);

    data_t    ring [NUM_TAPS];
    tap_idx_t newest;
    tap_idx_t next_slot;
    tap_idx_t rd_slot;

    // ******************************
    // slot arithmetic
    // ******************************
    // write slot wraps after NUM_TAPS entries
    assign next_slot = (newest == tap_idx_t'(NUM_TAPS - 1)) ? '0 : newest + 1'b1;

    // tap_idx positions back from the newest, modulo NUM_TAPS
    assign rd_slot = (newest >= tap_idx) ? newest - tap_idx
                                         : newest + tap_idx_t'(NUM_TAPS) - tap_idx;

    assign sample_out = ring[rd_slot];

    // newest slot pointer
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            newest <= tap_idx_t'(NUM_TAPS - 1);
        else if (start_req)
            newest <= tap_idx_t'(NUM_TAPS - 1);
        else if (sample_accept)
            newest <= next_slot;
    end

    // history storage
    always_ff @(posedge axis_clk)
    begin
        if (start_req)
        begin
            // zero prehistory for a new run
            for (int i = 0; i < NUM_TAPS; i++)
                ring[i] <= '0;
        end
        else if (sample_accept)
        begin
            ring[next_slot] <= ss_tdata;
        end
    end

endmodule

// File: logic/fir_tap_counter.sv
`timescale 1ns/1ps

module fir_tap_counter
    import fir_pkg::*;
(
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     start_req,
    input  length_t  run_length,
    input  logic     sample_accept,
    input  logic     mac_en,
    output tap_idx_t tap_idx,
    output logic     first_tap,
    output logic     last_tap,
    output length_t  remaining,
    output logic     last_sample
);

    assign first_tap = (tap_idx == '0);
    assign last_tap  = (tap_idx == tap_idx_t'(NUM_TAPS - 1));

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            tap_idx     <= '0;
            remaining   <= '0;
            last_sample <= 1'b0;
        end
        else if (start_req)
        begin
            tap_idx     <= '0;
            remaining   <= run_length;
            last_sample <= 1'b0;
        end
        else if (sample_accept)
        begin
            // new sample, fold from tap 0
            tap_idx     <= '0;
            remaining   <= remaining - 1'b1;
            // flags the sample taken while one was left
            last_sample <= (remaining == length_t'(1));
        end
        else if (mac_en && !last_tap)
        begin
            // holds on the last tap until the next sample
            tap_idx <= tap_idx + 1'b1;
        end
    end

endmodule

// File: logic/fir_seq_fsm.sv
`timescale 1ns/1ps

module fir_seq_fsm
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       start_req,
    input  logic       done_clear,
    input  logic       ss_tvalid,
    input  logic       has_free_slot,
    input  logic       last_tap,
    input  logic       last_sample,
    input  logic       fifo_empty,
    output logic       ss_tready,
    output logic       sample_accept,
    output logic       mac_en,
    output logic       result_push,
    output ap_status_t status
);

    fir_state_e state;
    logic       ap_start;
    logic       ap_idle;
    logic       ap_done;

    // ******************************
    // handshake and datapath strobes
    // ******************************
    // a sample is taken only with an output slot held for its result
    assign ss_tready     = (state == WAIT_SAMPLE) & has_free_slot;
    assign sample_accept = ss_tready & ss_tvalid;
    // one tap folded per cycle
    assign mac_en        = (state == MAC);
    assign result_push   = (state == PUSH);

    assign status.ap_start = ap_start;
    assign status.ap_idle  = ap_idle;
    assign status.ap_done  = ap_done;

    // ******************************
    // state and status bits
    // ******************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            state    <= IDLE;
            ap_start <= 1'b0;
            ap_idle  <= 1'b1;
            ap_done  <= 1'b0;
        end
        else
        begin
            // done cleared by a status read, a finishing run overrides
            if (done_clear)
                ap_done <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start_req)
                    begin
                        state    <= WAIT_SAMPLE;
                        ap_start <= 1'b1;
                        ap_idle  <= 1'b0;
                        ap_done  <= 1'b0;
                    end
                end
                WAIT_SAMPLE:
                begin
                    // start drops with the first sample
                    if (sample_accept)
                    begin
                        state    <= MAC;
                        ap_start <= 1'b0;
                    end
                end
                MAC:
                begin
                    if (last_tap)
                        state <= PUSH;
                end
                PUSH:
                begin
                    state <= last_sample ? DRAIN : WAIT_SAMPLE;
                end
                DRAIN:
                begin
                    // wait for the final beat to leave
                    if (fifo_empty)
                    begin
                        state   <= IDLE;
                        ap_done <= 1'b1;
                        ap_idle <= 1'b1;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/fir_cfg_regs.sv
`timescale 1ns/1ps

module fir_cfg_regs
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    // axi-lite write
    input  logic       awvalid,
    input  addr_t      awaddr,
    input  logic       wvalid,
    input  data_t      wdata,
    output logic       awready,
    output logic       wready,
    // axi-lite read
    input  logic       arvalid,
    input  addr_t      araddr,
    input  logic       rready,
    output logic       arready,
    output logic       rvalid,
    output data_t      rdata,
    // sequencer and counter side
    input  ap_status_t status,
    input  tap_idx_t   tap_idx,
    input  length_t    remaining,
    output logic       start_req,
    output logic       done_clear,
    output length_t    run_length,
    output data_t      tap_coef
);

    data_t coef [NUM_TAPS];
    logic  wr_fire;
    logic  wr_allowed;
    logic  rd_fire;

    // word aligned address inside the tap window
    function automatic logic is_tap_addr(input addr_t addr);
        return (addr >= ADDR_TAP_BASE) && (addr <= ADDR_TAP_LAST) && (addr[1:0] == 2'b00);
    endfunction

    // byte address to tap index
    function automatic tap_idx_t tap_of(input addr_t addr);
        addr_t offset;
        offset = addr - ADDR_TAP_BASE;
        return offset[2 +: TAP_IDX_W];
    endfunction

    // ******************************
    // write path
    // ******************************
    // address and data taken together in one cycle
    assign wr_fire    = awvalid & wvalid;
    assign awready    = wr_fire;
    assign wready     = wr_fire;
    // config only changes between runs
    assign wr_allowed = wr_fire & status.ap_idle;
    assign start_req  = wr_allowed & (awaddr == ADDR_CTRL) & wdata[0];

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            run_length <= '0;
        else if (wr_allowed && (awaddr == ADDR_LENGTH))
            run_length <= wdata;
    end

    // coefficient file
    always_ff @(posedge axis_clk)
    begin
        if (wr_allowed && is_tap_addr(awaddr))
            coef[tap_of(awaddr)] <= wdata;
    end

    // coefficient for the tap in flight
    assign tap_coef = coef[tap_idx];

    // ******************************
    // read path
    // ******************************
    // one response outstanding at most
    assign arready    = !rvalid;
    assign rd_fire    = arvalid & arready;
    // status read acknowledges done
    assign done_clear = rd_fire & (araddr == ADDR_CTRL);

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // response data captured on accept
    always_ff @(posedge axis_clk)
    begin
        if (rd_fire)
        begin
            if (araddr == ADDR_CTRL)
                rdata <= data_t'(status);
            else if (araddr == ADDR_LENGTH)
                rdata <= remaining;
            else if (is_tap_addr(araddr))
                rdata <= coef[tap_of(araddr)];
            else
                rdata <= '1;
        end
    end

endmodule

// File: logic/fir_pkg.sv
package fir_pkg;

    // ******************************
    // sizes
    // ******************************
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 12;
    localparam int LENGTH_W       = 32;
    localparam int NUM_TAPS       = 11;
    localparam int TAP_IDX_W      = 4;
    localparam int OUT_FIFO_DEPTH = 4;

    // output fifo pointer and occupancy widths
    localparam int FIFO_PTR_W = $clog2(OUT_FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(OUT_FIFO_DEPTH + 1);

    // ******************************
    // vector types
    // ******************************
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;
    typedef logic [LENGTH_W-1:0]  length_t;

    // register map
    localparam addr_t ADDR_CTRL     = 12'h000;
    localparam addr_t ADDR_LENGTH   = 12'h010;
    localparam addr_t ADDR_TAP_BASE = 12'h020;
    // one word per tap, last tap at 0x48
    localparam addr_t ADDR_TAP_LAST = ADDR_TAP_BASE + addr_t'(4 * (NUM_TAPS - 1));

    // ******************************
    // sequencer and bundles
    // ******************************
    typedef enum logic [2:0] {
        IDLE,
        WAIT_SAMPLE,
        MAC,
        PUSH,
        DRAIN
    } fir_state_e;

    // first member is msb, so ap_start lands in bit 0
    typedef struct packed {
        logic ap_done;
        logic ap_idle;
        logic ap_start;
    } ap_status_t;

    // one output stream beat
    typedef struct packed {
        data_t data;
        logic  last;
    } stream_beat_t;

endpackage
